/* files.f */
+incdir+verilog
verilog/code_pkg.sv
verilog/stream_pkg.sv
verilog/code_receiver.sv
verilog/bit_stuffer.sv
verilog/marker_escaper.sv
verilog/entropy_packer_top.sv
tests/tb_entropy_packer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the entropy packer testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns -f files.f \
    --top-module tb_entropy_packer -Mdir obj_dir -o sim_entropy_packer
./obj_dir/sim_entropy_packer | tee sim.log

if grep -q "^Verification passed$" sim.log; then
    echo "simulation log shows a passing run"
else
    echo "simulation log shows a failing run"
    exit 1
fi

/* tests/packer_trace.txt */
// one 48-bit hex record per token: type, group, 8-bit field, 32-bit data
// C code (field = length, data = code right aligned), F flush
// E expected bytes (field = last flag nibble, byte count nibble; data = bytes msb first)
C108000000A5 C11000001234 C1080000005C          // one aligned word
E104A512345C
C20100000001 C21B04000001 C20500000015          // codes straddle the word boundary
C20D00001ABC C20300000005 C20700000033 F20000000000
E204C000001A E213EAF2B300
C30C00000ABC F30000000000 E312ABC00000          // 12 bits pending, two bytes
C30400000009 C309000000F3 F30000000000 E31297980000
C4100000FF12 C410000034FF                       // 0xff inside a full word
C41B07FFFFFF F40000000000                       // 27 ones, four byte flush word
C408000000FF F40000000000                       // block ends on 0xff
E404FF001234 E404FF00FF00 E404FF00FF00 E411E0000000 E412FF000000
C51800010203 C51800040506 C51800070809 C518000A0B0C
C518000D0E0F C51800101112 C51800131415 C51800161718
E50401020304 E50405060708 E504090A0B0C E5040D0E0F10 E50411121314 E50415161718
F60000000000 C60A000002C5 F60000000000          // empty flush, then a new block
E612B1400000

/* tests/tb_entropy_packer.sv */
// ---------------------------------------------------------------------------
// trace-driven testbench for the entropy packer: four-phase source and sink,
// byte checker, watchdog and error summary
// ---------------------------------------------------------------------------
`include "packer_cfg.svh"

module tb_entropy_packer;
    timeunit 1ns;
    timeprecision 1ns;

    import code_pkg::*;
    import stream_pkg::*;

    logic        xclk;
    logic        rst;
    logic        in_req;
    code_in_t    in_code;
    logic        in_ack;
    logic        out_req;
    byte_out_t   out_byte;
    logic        out_ack;

    logic [47:0] trace [64];    // raw records from the trace file
    logic [47:0] stim_q [$];    // code and flush records in send order
    logic [8:0]  exp_q [$];     // {last, data} per expected byte
    logic [3:0]  exp_grp_q [$]; // test group of each expected byte
    string       test_name [8];
    integer      seed;
    int          n_records;
    int          mismatches;
    int          other_errors;

    entropy_packer_top u_entropy_packer_top (
        .xclk(xclk), .rst(rst), .in_req(in_req), .in_code(in_code), .in_ack(in_ack),
        .out_req(out_req), .out_byte(out_byte), .out_ack(out_ack)
    );

    initial begin
        xclk = 1'b0;
        forever #50 xclk = ~xclk;  // 100 ns period
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic load_trace();
        logic [47:0] rec;
        for (int i = 0; i < 64; i++) trace[i] = '0;  // type 0 ends the trace
        $readmemh("tests/packer_trace.txt", trace);
        n_records = 0;
        while (n_records < 64 && trace[n_records][47:44] != 4'h0) begin
            rec = trace[n_records];
            case (rec[47:44])
                4'hc, 4'hf: stim_q.push_back(rec);
                4'he: begin
                    for (int b = 0; b < rec[35:32]; b++) begin  // split into bytes
                        exp_q.push_back({rec[36] && (b == rec[35:32] - 1), rec[31-8*b -: 8]});
                        exp_grp_q.push_back(rec[43:40]);
                    end
                end
                default: begin
                    $display("trace record %0d has unknown type %h", n_records, rec[47:44]);
                    other_errors++;
                end
            endcase
            n_records++;
        end
        if (n_records == 0) begin
            $display("trace file is missing or holds no records");
            other_errors++;
        end
    endtask

    task automatic send_record(input logic [47:0] rec);
        code_in_t    code;
        logic [31:0] junk;
        int          shift;
        junk       = $random(seed);
        shift      = `PACK_CODE_W - int'(rec[36:32]);  // msb align the code
        code.flush = (rec[47:44] == 4'hf);
        code.len   = rec[36:32];
        code.bits  = (rec[`PACK_CODE_W-1:0] << shift)
                   | (junk[`PACK_CODE_W-1:0] & ~({`PACK_CODE_W{1'b1}} << shift));  // junk tail
        @(negedge xclk);
        in_code = code;
        in_req  = 1'b1;
        do @(negedge xclk); while (!in_ack);
        in_req  = 1'b0;
        do @(negedge xclk); while (in_ack);  // four-phase complete
    endtask

    task automatic take_byte();
        logic [8:0] exp;
        logic [3:0] grp;
        int         delay;
        if (exp_q.size() == 0) begin
            $display("DUT sent an extra byte %h after the expected stream", out_byte.data);
            other_errors++;
        end else begin
            exp = exp_q.pop_front();
            grp = exp_grp_q.pop_front();
            check_value({test_name[grp], " data"}, exp[7:0], out_byte.data);
            check_value({test_name[grp], " last"}, exp[8], out_byte.last);
            if (grp == 4'd5) begin
                delay = $random(seed) & 15;  // slow sink, lets the FIFO fill
                repeat (delay) @(negedge xclk);
            end
        end
        out_ack = 1'b1;
    endtask

    // sink side, acks one byte per four-phase transfer
    initial begin
        @(negedge rst);
        forever begin
            @(negedge xclk);
            if (out_req && !out_ack) take_byte();
            else if (!out_req && out_ack) out_ack = 1'b0;
        end
    end

    initial begin
        @(negedge rst);
        repeat (200 * n_records + 500) @(posedge xclk);
        $display("timeout, trace not finished after %0d cycles", 200 * n_records + 500);
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        $display("Verification failed");
        $finish;
    end

    initial begin
        seed         = 32'hcdf1;
        rst          = 1'b1;
        in_req       = 1'b0;
        in_code      = '0;
        out_ack      = 1'b0;
        mismatches   = 0;
        other_errors = 0;
        test_name[1] = "aligned";
        test_name[2] = "odd_lengths";
        test_name[3] = "flush";
        test_name[4] = "escaping";
        test_name[5] = "back_pressure";
        test_name[6] = "empty_flush";
        load_trace();
        repeat (8) @(posedge xclk);
        @(negedge xclk);
        rst = 1'b0;
        while (stim_q.size() > 0) send_record(stim_q.pop_front());
        while (exp_q.size() != 0) @(negedge xclk);
        repeat (40) @(negedge xclk);  // room for a stray extra byte
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* verilog/entropy_packer_top.sv */
// ---------------------------------------------------------------------------
// entropy output tail: code receiver, bit stuffer and marker escaper
// ---------------------------------------------------------------------------
module entropy_packer_top (
    input  logic                  xclk,
    input  logic                  rst,
    input  logic                  in_req,
    input  code_pkg::code_in_t    in_code,
    output logic                  in_ack,
    output logic                  out_req,
    output stream_pkg::byte_out_t out_byte,
    input  logic                  out_ack
);
    import code_pkg::*;
    import stream_pkg::*;

    code_beat_t beat;        // receiver to stuffer
    word_out_t  word;        // stuffer to escaper
    logic       word_valid;
    logic [3:0] fifo_space;  // credit back to the receiver

    code_receiver u_code_receiver (
        .xclk(xclk), .rst(rst), .in_req(in_req), .in_code(in_code),
        .in_ack(in_ack), .fifo_space(fifo_space), .beat(beat)
    );

    bit_stuffer u_bit_stuffer (
        .xclk(xclk), .rst(rst), .beat(beat), .word(word),
        .word_valid(word_valid), .flush_done()  // block end is seen on out_byte.last
    );

    marker_escaper u_marker_escaper (
        .xclk(xclk), .rst(rst), .word(word), .word_valid(word_valid),
        .fifo_space(fifo_space), .out_req(out_req), .out_ack(out_ack),
        .out_byte(out_byte)
    );

endmodule

/* verilog/marker_escaper.sv */
// ---------------------------------------------------------------------------
// word FIFO, byte serializer with 0x00 stuffed after every 0xFF, and the
// four-phase output master
// ---------------------------------------------------------------------------
`include "packer_cfg.svh"

module marker_escaper (
    input  logic                  xclk,
    input  logic                  rst,
    input  stream_pkg::word_out_t word,
    input  logic                  word_valid,
    output logic [3:0]            fifo_space,
    output logic                  out_req,
    input  logic                  out_ack,
    output stream_pkg::byte_out_t out_byte
);
    import stream_pkg::*;

    localparam int DEPTH = `PACK_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_DROP} state_t;

    word_out_t     mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    word_out_t     front;       // word being serialized
    logic [7:0]    cur_byte;
    logic          final_byte;  // cur_byte is the last valid byte of front
    logic          send;        // present a data byte this cycle
    logic          pop;
    logic [1:0]    byte_idx;
    logic          esc_pend;    // 0x00 still owed after an 0xff
    logic          esc_last;
    state_t        state;

    assign front      = mem[rd_ptr];
    assign cur_byte   = front.data.bytes[byte_idx];
    assign final_byte = (byte_idx == front.nbytes - 2'd1);  // nbytes 0 gives index 3
    assign send       = (state == S_IDLE) && !esc_pend && (count != '0);
    assign pop        = send && final_byte;
    assign fifo_space = 4'(DEPTH) - 4'(count);

    always_ff @(posedge xclk) begin
        if (word_valid) mem[wr_ptr] <= word;  // always taken, credit keeps room
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (word_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop)        rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{AW{1'b0}}, word_valid} - {{AW{1'b0}}, pop};
        end
    end

    always_ff @(posedge xclk) begin
        if (state == S_IDLE && esc_pend) begin
            out_byte.data <= 8'h00;
            out_byte.last <= esc_last;    // stuffed byte closes the block
        end else if (send) begin
            out_byte.data <= cur_byte;
            out_byte.last <= front.last && final_byte && (cur_byte != 8'hff);
        end
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            state    <= S_IDLE;
            out_req  <= 1'b0;
            byte_idx <= '0;
            esc_pend <= 1'b0;
            esc_last <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (esc_pend) begin
                        esc_pend <= 1'b0;
                        out_req  <= 1'b1;
                        state    <= S_REQ;
                    end else if (send) begin
                        esc_pend <= (cur_byte == 8'hff);
                        esc_last <= front.last && final_byte;
                        byte_idx <= final_byte ? 2'd0 : byte_idx + 2'd1;
                        out_req  <= 1'b1;
                        state    <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (out_ack) begin   // sink took the byte
                        out_req <= 1'b0;
                        state   <= S_DROP;
                    end
                end
                S_DROP: if (!out_ack) state <= S_IDLE;  // next byte only after ack falls
                default: state <= S_IDLE;
            endcase
        end
    end

    // relies on the receiver credit check covering the stuffer pipeline
    fifo_no_overflow: assert property (@(posedge xclk) disable iff (rst)
        word_valid |-> (count < (AW+1)'(DEPTH)));

endmodule

/* verilog/bit_stuffer.sv */
// ---------------------------------------------------------------------------
// three-stage barrel shifter packing msb aligned codes into 32-bit words,
// flush emits the zero padded partial word and restarts at bit 0
// ---------------------------------------------------------------------------
`include "packer_cfg.svh"

module bit_stuffer (
    input  logic                 xclk,
    input  logic                 rst,
    input  code_pkg::code_beat_t beat,
    output stream_pkg::word_out_t word,
    output logic                 word_valid,
    output logic                 flush_done
);
    import stream_pkg::*;

    localparam int CW  = `PACK_CODE_W;
    localparam int WW  = `PACK_WORD_W;
    localparam int PW  = $clog2(WW);  // bit position width
    localparam int S1W = CW + 24;     // after 0/8/16/24 shift
    localparam int S2W = CW + 30;     // after 0/2/4/6 shift
    localparam int S3W = CW + 31;     // after 0/1 shift, top WW bits land in the word

    logic [PW-1:0]  pos;       // bits already in the current word
    logic [PW:0]    pos_sum;   // msb is the carry past the word boundary
    logic [CW-1:0]  code_clean;

    logic           s1_ds;
    logic           s1_flush;
    logic           s1_full;
    logic [PW-1:0]  s1_pos;
    logic [S1W-1:0] s1_data;

    logic           s2_ds;
    logic           s2_flush;
    logic           s2_full;
    logic [PW-1:0]  s2_pos;
    logic [S2W-1:0] s2_data;
    logic [WW-1:0]  s2_mask;   // 1 takes new code bits, 0 keeps held bits

    logic           s3_flush;
    logic [S3W-1:0] s3_data;
    logic [WW-1:0]  hold;      // partial word being filled
    logic [PW:0]    pad_sum;
    packed_word_u   merged;

    // drop the garbage below len so padding and spill stay zero
    assign code_clean = beat.bits & ~({CW{1'b1}} >> beat.len);
    assign pos_sum    = {1'b0, pos} + {1'b0, beat.len};

    always_ff @(posedge xclk) begin
        if (rst || beat.flush) pos <= '0;     // next block starts at bit 0
        else if (beat.ds)      pos <= pos_sum[PW-1:0];
    end

    // stage 1, coarse byte shift
    always_ff @(posedge xclk) begin
        s1_pos  <= pos;                        // flush also carries the pending count
        s1_full <= pos_sum[PW];
        s1_data <= {code_clean, 24'b0} >> {pos[PW-1:3], 3'b0};
    end

    // stage 2, 2-bit shift and merge mask
    always_ff @(posedge xclk) begin
        s2_pos  <= s1_pos;
        s2_full <= s1_full;
        s2_data <= {s1_data, 6'b0} >> {s1_pos[2:1], 1'b0};
        s2_mask <= {WW{1'b1}} >> s1_pos;
    end

    // stage 3, final 1-bit shift and merge with held bits
    assign s3_data     = {s2_data, 1'b0} >> s2_pos[0];
    assign merged.word = (hold & ~s2_mask) | (s3_data[S3W-1 -: WW] & s2_mask);
    assign pad_sum     = {1'b0, s2_pos} + (PW+1)'(7);  // ceil to whole bytes

    always_ff @(posedge xclk) begin
        if (s2_ds) begin
            if (s2_full) hold <= {s3_data[S3W-WW-1:0], {(2*WW-S3W){1'b0}}};  // spill
            else         hold <= merged.word;
        end else if (s2_flush) begin
            hold <= '0;
        end
    end

    always_ff @(posedge xclk) begin
        word.data.word <= s2_flush ? hold : merged.word;
        word.nbytes    <= s2_flush ? pad_sum[4:3] : 2'd0;  // full words carry 4
        word.last      <= s2_flush;
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            s1_ds      <= 1'b0;
            s1_flush   <= 1'b0;
            s2_ds      <= 1'b0;
            s2_flush   <= 1'b0;
            s3_flush   <= 1'b0;
            word_valid <= 1'b0;
            flush_done <= 1'b0;
        end else begin
            s1_ds      <= beat.ds;
            s1_flush   <= beat.flush;
            s2_ds      <= s1_ds;
            s2_flush   <= s1_flush;
            s3_flush   <= s2_flush;
            word_valid <= (s2_ds && s2_full) || (s2_flush && s2_pos != '0);
            flush_done <= s3_flush;   // one cycle after any flush word
        end
    end

    // receiver derives ds and flush from one transfer, never both
    ds_flush_excl: assert property (@(posedge xclk) disable iff (rst)
        !(beat.ds && beat.flush));

endmodule

/* verilog/code_receiver.sv */
// ---------------------------------------------------------------------------
// four-phase input slave, turns each accepted transfer into one code or
// flush beat, holds off while the escaper FIFO is short of credit
// ---------------------------------------------------------------------------
`include "packer_cfg.svh"

module code_receiver (
    input  logic                 xclk,
    input  logic                 rst,
    input  logic                 in_req,
    input  code_pkg::code_in_t   in_code,
    output logic                 in_ack,
    input  logic [3:0]           fifo_space,
    output code_pkg::code_beat_t beat
);
    import code_pkg::*;

    localparam logic [3:0] CREDIT_MIN = 4'd4;  // 3 words in the stuffer + 1 new

    typedef enum logic {S_WAIT, S_ACKED} state_t;

    state_t     state;
    logic       take;    // transfer accepted this cycle
    code_beat_t beat_n;

    assign take   = (state == S_WAIT) && in_req && (fifo_space >= CREDIT_MIN);
    assign in_ack = (state == S_ACKED);  // rises with the beat strobe

    always_comb begin
        beat_n.bits  = in_code.bits;
        beat_n.len   = in_code.len;
        beat_n.ds    = take && !in_code.flush;
        beat_n.flush = take && in_code.flush;
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            state <= S_WAIT;
        end else begin
            case (state)
                S_WAIT:  if (take) state <= S_ACKED;
                S_ACKED: if (!in_req) state <= S_WAIT;  // source dropped req, drop ack
                default: state <= S_WAIT;
            endcase
        end
    end

    always_ff @(posedge xclk) begin
        beat.bits <= beat_n.bits;  // payload, only meaningful with ds
        beat.len  <= beat_n.len;
        if (rst) begin
            beat.ds    <= 1'b0;
            beat.flush <= 1'b0;
        end else begin
            beat.ds    <= beat_n.ds;
            beat.flush <= beat_n.flush;
        end
    end

    // the stuffer position math relies on a legal length from the source
    ds_len_legal: assert property (@(posedge xclk) disable iff (rst)
        beat.ds |-> (beat.len != 5'd0 && beat.len <= 5'(`PACK_CODE_W)));

endmodule

/* verilog/stream_pkg.sv */
// ---------------------------------------------------------------------------
// output-side types: packed word with word/byte views, word and byte beats
// ---------------------------------------------------------------------------
`include "packer_cfg.svh"

package stream_pkg;

    // stuffer fills it as a bit field, escaper walks it byte by byte
    typedef union packed {
        logic [`PACK_WORD_W-1:0]           word;
        logic [0:`PACK_WORD_W/8-1][7:0]    bytes;  // bytes[0] is the msb byte
    } packed_word_u;

    typedef struct packed {
        packed_word_u data;
        logic [1:0]   nbytes;  // valid bytes, 0 means all 4
        logic         last;    // flush word closing the block
    } word_out_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;      // final byte of the block
    } byte_out_t;

endpackage

/* verilog/code_pkg.sv */
// ---------------------------------------------------------------------------
// input-side types: code transfer from the source and the one-cycle beat
// that the receiver hands to the bit stuffer
// ---------------------------------------------------------------------------
`include "packer_cfg.svh"

package code_pkg;

    typedef struct packed {
        logic [`PACK_CODE_W-1:0] bits;   // msb aligned, tail below len is don't care
        logic [4:0]              len;    // 1..27
        logic                    flush;  // close the block, bits/len ignored
    } code_in_t;

    typedef struct packed {
        logic [`PACK_CODE_W-1:0] bits;
        logic [4:0]              len;
        logic                    ds;     // single-cycle code strobe
        logic                    flush;  // single-cycle flush strobe
    } code_beat_t;

endpackage

/* verilog/packer_cfg.svh */
// ---------------------------------------------------------------------------
// entropy packer sizes: code width, packed word width, escaper FIFO depth
// ---------------------------------------------------------------------------
`ifndef PACKER_CFG_SVH
`define PACKER_CFG_SVH

`define PACK_CODE_W     27   // longest variable-length code, MSB aligned
`define PACK_WORD_W     32   // bit stuffer output word
`define PACK_FIFO_DEPTH 8    // words buffered ahead of the byte serializer

`endif
